//--- sources.f
hw/rv_pkg.sv
hw/reg_file.sv
hw/pipeline_control.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/rv_core.sv
testbench/tb_mem_model.sv
testbench/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_rv_core -o sim_rv_core \
    && ./obj_dir/sim_rv_core 2>&1 | tee sim.log \
    || { echo "build or run failed"; exit 1; }

[ -f sim.log ] || { echo "no log produced"; exit 1; }
grep -q "Simulation failed" sim.log && exit 1 || exit 0

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int BUDGET      = 300;   // cycles per program run
    localparam int NUM_RUNS    = 6;
    localparam int WATCHDOG_NS = NUM_RUNS * (BUDGET + 4) * 10 * 4;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        stall_en = 1'b0;
    logic [29:0] icache_addr, dcache_addr;
    logic [31:0] icache_rdata, dcache_rdata, dcache_wdata;
    logic        icache_stall, dcache_stall, dcache_ren, dcache_wen;

    logic [31:0] prog [$];
    logic [29:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [29:0] got_addr [$];
    logic [31:0] got_data [$];
    int          exp_loads = 0;
    int          loads_seen = 0;
    int          errors = 0;
    int          checks = 0;

    rv_core #(.RESET_PC(32'h0)) UUT (
        .clk, .rst_n, .icache_addr, .icache_rdata, .icache_stall,
        .dcache_ren, .dcache_wen, .dcache_addr, .dcache_wdata, .dcache_rdata, .dcache_stall
    );

    tb_mem_model mem (
        .clk, .stall_en, .icache_addr, .icache_rdata, .icache_stall,
        .dcache_ren, .dcache_wen, .dcache_addr, .dcache_wdata, .dcache_rdata, .dcache_stall
    );

    always #5 clk = ~clk;

    // every store that commits to memory, and every load that completes
    always @(posedge clk) begin
        if (rst_n && !icache_stall && !dcache_stall) begin
            if (dcache_wen) begin
                got_addr.push_back(dcache_addr);
                got_data.push_back(dcache_wdata);
            end
            if (dcache_ren)
                loads_seen++;
        end
    end

    function automatic logic [31:0] r_ins(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_ins(int op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_ins(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_ins(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_ins(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // data memory background, a function of the full word index
    function automatic logic [31:0] fill_word(int idx);
        return (32'(idx) * 32'h0001_0003) ^ 32'hc0de_0000;
    endfunction

    // reference results from the RV32I definitions
    function automatic logic [31:0] ref_alu(int f3, int alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0:       return (alt != 0) ? a - b : a + b;
            1:       return a << b[4:0];
            2:       return {31'b0, $signed(a) < $signed(b)};
            4:       return a ^ b;
            5: begin
                if (alt != 0)
                    return $signed(a) >>> b[4:0];   // sign bit fills from the left
                return a >> b[4:0];
            end
            6:       return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic expect_store(int byte_addr, logic [31:0] data);
        exp_addr.push_back(30'(byte_addr >> 2));
        exp_data.push_back(data);
    endtask

    task automatic start_test();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_loads = 0;
    endtask

    // load, reset, run to the closing self-jump, then let the pipe drain
    task automatic run_program(string name, logic stalls);
        logic [29:0] halt_addr;
        int          cycles;
        int          drain;
        logic        seen;
        halt_addr = 30'(prog.size() - 1);
        cycles = 0;
        drain = 0;
        seen = 1'b0;
        @(negedge clk);
        rst_n = 1'b0;
        stall_en = stalls;
        for (int i = 0; i < 1024; i++) begin
            mem.imem[i] = 32'h0;
            mem.dmem[i] = fill_word(i);
        end
        foreach (prog[i])
            mem.imem[i] = prog[i];
        got_addr.delete();
        got_data.delete();
        loads_seen = 0;
        repeat (2) @(negedge clk);
        checks++;
        assert (icache_addr == 30'h0 && !dcache_ren && !dcache_wen) else begin
            errors++;
            $display("%s: in reset the PC is off the reset vector or the data port is active",
                     name);
        end
        rst_n = 1'b1;
        while (drain < 8 && cycles < BUDGET) begin
            @(negedge clk);
            cycles++;
            if (icache_addr == halt_addr)
                seen = 1'b1;
            if (seen && !icache_stall && !dcache_stall)
                drain++;
        end
        checks++;
        assert (drain >= 8) else begin
            errors++;
            $display("%s: program never reached its final self-jump within %0d cycles",
                     name, BUDGET);
        end
    endtask

    task automatic check_stores(string name);
        checks++;
        assert (got_addr.size() == exp_addr.size()) else begin
            errors++;
            $display("%s: saw %0d stores where %0d were expected",
                     name, got_addr.size(), exp_addr.size());
        end
        foreach (exp_addr[i]) begin
            checks++;
            if (i >= got_addr.size()) begin
                assert (0) else begin
                    errors++;
                    $display("%s: store %0d to word %h never happened", name, i, exp_addr[i]);
                end
            end else begin
                assert (got_addr[i] == exp_addr[i] && got_data[i] == exp_data[i]) else begin
                    errors++;
                    $display("FAIL %s store %0d: expected [%h]=%h actual [%h]=%h", name, i,
                             exp_addr[i], exp_data[i], got_addr[i], got_data[i]);
                end
            end
        end
    endtask

    task automatic check_loads(string name);
        checks++;
        assert (loads_seen == exp_loads) else begin
            errors++;
            $display("FAIL %s load count: expected %0d actual %0d", name, exp_loads, loads_seen);
        end
    endtask

    task automatic test_alu();
        int          f3s [9] = '{0, 0, 1, 2, 4, 5, 5, 6, 7};
        int          alts [9] = '{0, 1, 0, 0, 0, 0, 1, 0, 0};
        logic [31:0] a;
        a = 32'hffff_ffec;   // -20, exercises signed slt and sra
        start_test();
        prog.push_back(i_ins(7'h13, 0, 1, 0, -20));
        prog.push_back(i_ins(7'h13, 0, 2, 0, 3));
        for (int k = 0; k < 9; k++) begin
            prog.push_back(r_ins(alts[k] * 32, f3s[k], 3, 1, 2));
            prog.push_back(s_ins(3, 0, 256 + 4 * k));
            expect_store(256 + 4 * k, ref_alu(f3s[k], alts[k], a, 32'd3));
        end
        for (int k = 0; k < 9; k++) begin
            if (k != 1) begin   // no subi
                prog.push_back(i_ins(7'h13, f3s[k], 3, 1, (alts[k] != 0) ? 1027 : 3));
                prog.push_back(s_ins(3, 0, 384 + 4 * k));
                expect_store(384 + 4 * k, ref_alu(f3s[k], alts[k], a, 32'd3));
            end
        end
        prog.push_back(j_ins(0, 0));
        run_program("alu", 1'b0);
        check_stores("alu");
        check_loads("alu");
    endtask

    task automatic test_forwarding(logic stalls);
        start_test();
        prog.push_back(i_ins(7'h13, 0, 5, 0, 7));       // x5 = 7
        prog.push_back(i_ins(7'h13, 0, 6, 5, 5));       // x6 = 12
        prog.push_back(r_ins(0, 0, 7, 6, 5));           // x7 = 19
        prog.push_back(r_ins(0, 4, 8, 7, 6));           // x8 = 31
        prog.push_back(s_ins(8, 0, 512));
        prog.push_back(s_ins(7, 0, 516));
        prog.push_back(r_ins(0, 0, 9, 8, 7));           // x9 = 50
        prog.push_back(s_ins(9, 0, 520));
        prog.push_back(j_ins(0, 0));
        expect_store(512, 32'd31);
        expect_store(516, 32'd19);
        expect_store(520, 32'd50);
        run_program(stalls ? "forwarding_stalled" : "forwarding", stalls);
        check_stores(stalls ? "forwarding_stalled" : "forwarding");
        check_loads(stalls ? "forwarding_stalled" : "forwarding");
    endtask

    task automatic test_load_use();
        start_test();
        prog.push_back(i_ins(7'h03, 2, 10, 0, 64));
        prog.push_back(r_ins(0, 0, 11, 10, 10));
        prog.push_back(s_ins(11, 0, 768));
        prog.push_back(i_ins(7'h03, 2, 12, 0, 68));
        prog.push_back(s_ins(12, 0, 772));             // store data straight from a load
        prog.push_back(j_ins(0, 0));
        expect_store(768, fill_word(16) + fill_word(16));
        expect_store(772, fill_word(17));
        exp_loads = 2;
        run_program("load_use", 1'b0);
        check_stores("load_use");
        check_loads("load_use");
    endtask

    task automatic test_control(logic stalls);
        start_test();
        prog.push_back(i_ins(7'h13, 0, 1, 0, 5));       // 0
        prog.push_back(i_ins(7'h13, 0, 2, 0, 5));       // 4
        prog.push_back(b_ins(0, 1, 2, 8));              // 8  beq taken
        prog.push_back(s_ins(1, 0, 1024));              // 12 skipped
        prog.push_back(b_ins(1, 1, 2, 8));              // 16 bne not taken
        prog.push_back(s_ins(2, 0, 1028));              // 20
        prog.push_back(i_ins(7'h13, 0, 3, 0, 9));       // 24
        prog.push_back(b_ins(1, 3, 1, 8));              // 28 bne taken
        prog.push_back(s_ins(3, 0, 1032));              // 32 skipped
        prog.push_back(b_ins(0, 3, 1, 8));              // 36 beq not taken
        prog.push_back(s_ins(3, 0, 1036));              // 40
        prog.push_back(j_ins(4, 8));                    // 44 jal, x4 = 48
        prog.push_back(s_ins(0, 0, 1040));              // 48 skipped
        prog.push_back(s_ins(4, 0, 1044));              // 52
        prog.push_back(i_ins(7'h13, 0, 5, 0, 73));      // 56 odd target
        prog.push_back(i_ins(7'h67, 0, 6, 5, 0));       // 60 jalr to 72, x6 = 64
        prog.push_back(s_ins(0, 0, 1048));              // 64 skipped
        prog.push_back(s_ins(0, 0, 1052));              // 68 skipped
        prog.push_back(s_ins(6, 0, 1056));              // 72
        prog.push_back(j_ins(0, 0));
        expect_store(1028, 32'd5);
        expect_store(1036, 32'd9);
        expect_store(1044, 32'd48);
        expect_store(1056, 32'd64);
        run_program(stalls ? "control_stalled" : "control", stalls);
        check_stores(stalls ? "control_stalled" : "control");
        check_loads(stalls ? "control_stalled" : "control");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the core stopped making progress", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        test_alu();
        test_forwarding(1'b0);
        test_load_use();
        test_control(1'b0);
        test_forwarding(1'b1);   // same programs under random stalls
        test_control(1'b1);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        clk,
    input  logic        stall_en,
    input  logic [29:0] icache_addr,
    output logic [31:0] icache_rdata,
    output logic        icache_stall,
    input  logic        dcache_ren,
    input  logic        dcache_wen,
    input  logic [29:0] dcache_addr,
    input  logic [31:0] dcache_wdata,
    output logic [31:0] dcache_rdata,
    output logic        dcache_stall
);

    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    int          seed = 3362;

    initial begin
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
    end

    // combinational reads, only 4 KiB of each space modelled
    assign icache_rdata = imem[icache_addr[9:0]];
    assign dcache_rdata = dcache_ren ? dmem[dcache_addr[9:0]] : 32'h0;

    // roughly one stall cycle in four on each side
    always @(negedge clk) begin
        if (stall_en) begin
            icache_stall <= (($random(seed) & 3) == 0);
            dcache_stall <= (($random(seed) & 3) == 0);
        end else begin
            icache_stall <= 1'b0;
            dcache_stall <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (dcache_wen && !icache_stall && !dcache_stall)
            dmem[dcache_addr[9:0]] <= dcache_wdata;
    end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::mem_addr_t icache_addr,
    input  rv_pkg::word_t     icache_rdata,
    input  logic              icache_stall,
    output logic              dcache_ren,
    output logic              dcache_wen,
    output rv_pkg::mem_addr_t dcache_addr,
    output rv_pkg::word_t     dcache_wdata,
    input  rv_pkg::word_t     dcache_rdata,
    input  logic              dcache_stall
);
    import rv_pkg::*;

    logic      stall, flush, load_bubble, redirect, use_rs1_target, rs_equal;
    logic      reg_write, mem_read, mem_write, alu_src, is_link;
    alu_op_e   alu_op;
    imm_fmt_e  imm_fmt;
    fwd_sel_t  fwd_a, fwd_b, fwd_id_a, fwd_id_b;
    word_t     id_pc, id_inst, redirect_target;
    word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    logic      ex_reg_write, ex_mem_read, ex_mem_write, ex_alu_src, ex_is_link;
    alu_op_e   ex_alu_op;
    word_t     mem_result, mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_reg_write, mem_mem_read, mem_mem_write;
    reg_addr_t wb_rd;
    logic      wb_reg_write;
    word_t     wb_data;

    pipeline_control u_control (.*);

    // a load bubble holds fetch while the rest of the pipe drains
    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk, .rst_n,
        .stall (stall || load_bubble),
        .redirect, .redirect_target, .icache_rdata, .icache_addr, .id_pc, .id_inst
    );

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    mem_wb_stage u_mem_wb (.*);

endmodule

//--- hw/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::word_t     mem_result,
    input  rv_pkg::word_t     mem_store_data,
    input  rv_pkg::reg_addr_t mem_rd,
    input  logic              mem_reg_write,
    input  logic              mem_mem_read,
    input  logic              mem_mem_write,
    input  rv_pkg::word_t     dcache_rdata,
    output logic              dcache_ren,
    output logic              dcache_wen,
    output rv_pkg::mem_addr_t dcache_addr,
    output rv_pkg::word_t     dcache_wdata,
    output rv_pkg::reg_addr_t wb_rd,
    output logic              wb_reg_write,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    logic  wb_is_load;
    word_t wb_result, wb_load;

    assign dcache_ren   = mem_mem_read;
    assign dcache_wen   = mem_mem_write;
    assign dcache_addr  = mem_result[XLEN-1:2];   // word aligned only
    assign dcache_wdata = mem_store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_write <= 1'b0;
            wb_is_load   <= 1'b0;
        end else if (!stall) begin
            wb_reg_write <= mem_reg_write;
            wb_is_load   <= mem_mem_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rd     <= mem_rd;
            wb_result <= mem_result;
            wb_load   <= dcache_rdata;
        end
    end

    assign wb_data = wb_is_load ? wb_load : wb_result;

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::word_t     ex_pc,
    input  rv_pkg::word_t     ex_rs1_data,
    input  rv_pkg::word_t     ex_rs2_data,
    input  rv_pkg::word_t     ex_imm,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              ex_reg_write,
    input  logic              ex_mem_read,
    input  logic              ex_mem_write,
    input  logic              ex_alu_src,
    input  logic              ex_is_link,
    input  rv_pkg::alu_op_e   ex_alu_op,
    input  rv_pkg::fwd_sel_t  fwd_a,
    input  rv_pkg::fwd_sel_t  fwd_b,
    input  rv_pkg::word_t     wb_data,
    output rv_pkg::word_t     mem_result,
    output rv_pkg::word_t     mem_store_data,
    output rv_pkg::reg_addr_t mem_rd,
    output logic              mem_reg_write,
    output logic              mem_mem_read,
    output logic              mem_mem_write
);
    import rv_pkg::*;

    word_t op_a, op_b_reg, op_b;
    word_t alu_out, ex_out;

    assign op_a     = fwd_mux(fwd_a, ex_rs1_data, mem_result, wb_data);
    assign op_b_reg = fwd_mux(fwd_b, ex_rs2_data, mem_result, wb_data);   // also store data
    assign op_b     = ex_alu_src ? ex_imm : op_b_reg;

    always_comb begin
        case (ex_alu_op)
            alu_add: alu_out = op_a + op_b;
            alu_sub: alu_out = op_a - op_b;
            alu_sll: alu_out = op_a << op_b[4:0];
            alu_slt: alu_out = word_t'($signed(op_a) < $signed(op_b));
            alu_xor: alu_out = op_a ^ op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_and: alu_out = op_a & op_b;
            alu_srl: alu_out = op_a >> op_b[4:0];
            alu_sra: alu_out = $signed(op_a) >>> op_b[4:0];
            default: alu_out = op_a + op_b;
        endcase
    end

    // jal/jalr write the return address through the normal result path
    assign ex_out = ex_is_link ? ex_pc + 32'd4 : alu_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else if (!stall) begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_result     <= ex_out;
            mem_store_data <= op_b_reg;
            mem_rd         <= ex_rd;
        end
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  logic              load_bubble,
    input  logic              use_rs1_target,
    input  rv_pkg::word_t     id_pc,
    input  rv_pkg::word_t     id_inst,
    input  logic              reg_write,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              alu_src,
    input  logic              is_link,
    input  rv_pkg::alu_op_e   alu_op,
    input  rv_pkg::imm_fmt_e  imm_fmt,
    input  rv_pkg::fwd_sel_t  fwd_id_a,
    input  rv_pkg::fwd_sel_t  fwd_id_b,
    input  rv_pkg::word_t     mem_result,
    input  rv_pkg::word_t     wb_data,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              wb_reg_write,
    output rv_pkg::word_t     redirect_target,
    output logic              rs_equal,
    output rv_pkg::word_t     ex_pc,
    output rv_pkg::word_t     ex_rs1_data,
    output rv_pkg::word_t     ex_rs2_data,
    output rv_pkg::word_t     ex_imm,
    output rv_pkg::reg_addr_t ex_rs1,
    output rv_pkg::reg_addr_t ex_rs2,
    output rv_pkg::reg_addr_t ex_rd,
    output logic              ex_reg_write,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_alu_src,
    output logic              ex_is_link,
    output rv_pkg::alu_op_e   ex_alu_op
);
    import rv_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rf_rs1, rf_rs2;
    word_t     rs1_val, rs2_val;
    word_t     imm, jalr_sum;
    logic      kill;

    assign rs1 = id_inst[19:15];
    assign rs2 = id_inst[24:20];
    assign rd  = id_inst[11:7];

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (wb_rd),
        .wen      (wb_reg_write),
        .rd_data  (wb_data),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2)
    );

    always_comb begin
        case (imm_fmt)
            imm_i:   imm = {{20{id_inst[31]}}, id_inst[31:20]};
            imm_s:   imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
            imm_b:   imm = {{20{id_inst[31]}}, id_inst[7], id_inst[30:25], id_inst[11:8], 1'b0};
            imm_j:   imm = {{12{id_inst[31]}}, id_inst[19:12], id_inst[20], id_inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // bypassed operands, also what goes into ID/EX
    assign rs1_val  = fwd_mux(fwd_id_a, rf_rs1, mem_result, wb_data);
    assign rs2_val  = fwd_mux(fwd_id_b, rf_rs2, mem_result, wb_data);
    assign rs_equal = (rs1_val == rs2_val);

    assign jalr_sum        = rs1_val + imm;
    assign redirect_target = use_rs1_target ? {jalr_sum[XLEN-1:1], 1'b0} : id_pc + imm;

    // taken branches need nothing downstream, jumps still carry the link
    assign kill = load_bubble || (flush && !is_link);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_alu_src   <= 1'b0;
            ex_is_link   <= 1'b0;
            ex_alu_op    <= alu_add;
        end else if (!stall) begin
            ex_reg_write <= reg_write && !kill;
            ex_mem_read  <= mem_read && !kill;
            ex_mem_write <= mem_write && !kill;
            ex_alu_src   <= alu_src && !kill;
            ex_is_link   <= is_link && !kill;
            ex_alu_op    <= kill ? alu_add : alu_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_pc       <= id_pc;
            ex_rs1_data <= rs1_val;
            ex_rs2_data <= rs2_val;
            ex_imm      <= imm;
            ex_rs1      <= rs1;
            ex_rs2      <= rs2;
            ex_rd       <= rd;
        end
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              redirect,
    input  rv_pkg::word_t     redirect_target,
    input  rv_pkg::word_t     icache_rdata,
    output rv_pkg::mem_addr_t icache_addr,
    output rv_pkg::word_t     id_pc,
    output rv_pkg::word_t     id_inst
);
    import rv_pkg::*;

    word_t pc;

    assign icache_addr = pc[XLEN-1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            id_inst <= '0;
        end else if (!stall) begin
            if (redirect) begin
                pc      <= redirect_target;
                id_inst <= '0;              // wrong-path fetch becomes a bubble
            end else begin
                pc      <= pc + 32'd4;
                id_inst <= icache_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            id_pc <= pc;
    end

endmodule

//--- hw/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
    input  rv_pkg::word_t     id_inst,
    input  logic              rs_equal,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              ex_mem_read,
    input  logic              ex_reg_write,
    input  rv_pkg::reg_addr_t ex_rs1,
    input  rv_pkg::reg_addr_t ex_rs2,
    input  rv_pkg::reg_addr_t mem_rd,
    input  logic              mem_reg_write,
    input  logic              mem_mem_read,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              wb_reg_write,
    input  logic              icache_stall,
    input  logic              dcache_stall,
    output logic              stall,
    output logic              flush,
    output logic              load_bubble,
    output logic              redirect,
    output logic              use_rs1_target,
    output logic              reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              alu_src,
    output logic              is_link,
    output rv_pkg::alu_op_e   alu_op,
    output rv_pkg::imm_fmt_e  imm_fmt,
    output rv_pkg::fwd_sel_t  fwd_a,
    output rv_pkg::fwd_sel_t  fwd_b,
    output rv_pkg::fwd_sel_t  fwd_id_a,
    output rv_pkg::fwd_sel_t  fwd_id_b
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       uses_rs1, uses_rs2, needs_id_ops;
    logic       ex_hit, mem_hit, taken;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    // youngest producer wins, x0 never bypassed
    function automatic fwd_sel_t fwd_pick(input reg_addr_t src, input logic mem_ok);
        if (src == '0)
            return FWD_REG;
        if (mem_ok && mem_reg_write && mem_rd == src)
            return FWD_MEM;
        if (wb_reg_write && wb_rd == src)
            return FWD_WB;
        return FWD_REG;
    endfunction

    assign opcode = opcode_e'(id_inst[6:0]);
    assign funct3 = id_inst[14:12];
    assign rs1    = id_inst[19:15];
    assign rs2    = id_inst[24:20];

    assign uses_rs1     = opcode inside {op_reg, op_imm, op_load, op_store, op_branch, op_jalr};
    assign uses_rs2     = opcode inside {op_reg, op_store, op_branch};
    assign needs_id_ops = opcode inside {op_branch, op_jalr};   // operands consumed in decode

    always_comb begin
        reg_write      = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        alu_src        = 1'b0;
        is_link        = 1'b0;
        use_rs1_target = 1'b0;
        alu_op         = alu_add;
        imm_fmt        = imm_none;
        case (opcode)
            op_reg: begin
                reg_write = 1'b1;
                alu_op    = alu_sel(funct3, id_inst[30]);
            end
            op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm_fmt   = imm_i;
                alu_op    = alu_sel(funct3, id_inst[30] && funct3 == 3'b101);  // addi ignores bit 30
            end
            op_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
                imm_fmt   = imm_i;
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_fmt   = imm_s;
            end
            op_branch: imm_fmt = imm_b;
            op_jal: begin
                reg_write = 1'b1;
                is_link   = 1'b1;
                imm_fmt   = imm_j;
            end
            op_jalr: begin
                reg_write      = 1'b1;
                is_link        = 1'b1;
                imm_fmt        = imm_i;
                use_rs1_target = 1'b1;
            end
            default: ;   // bubble or unsupported
        endcase
    end

    assign ex_hit  = (ex_rd != '0) &&
                     ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));
    assign mem_hit = (mem_rd != '0) &&
                     ((uses_rs1 && mem_rd == rs1) || (uses_rs2 && mem_rd == rs2));

    assign load_bubble = (ex_mem_read && ex_hit) ||
                         (needs_id_ops && ex_reg_write && ex_hit) ||
                         (needs_id_ops && mem_mem_read && mem_hit);

    assign stall = icache_stall || dcache_stall;   // global freeze

    assign taken    = (opcode == op_branch) &&
                      ((funct3 == FUNCT3_BEQ && rs_equal) || (funct3 == FUNCT3_BNE && !rs_equal));
    assign redirect = !load_bubble && (taken || opcode == op_jal || opcode == op_jalr);
    assign flush    = redirect;   // squash the fetched successor

    always_comb begin
        fwd_a    = fwd_pick(ex_rs1, 1'b1);
        fwd_b    = fwd_pick(ex_rs2, 1'b1);
        // load data is not ready in EX/MEM for decode
        fwd_id_a = fwd_pick(rs1, !mem_mem_read);
        fwd_id_b = fwd_pick(rs2, !mem_mem_read);
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              wen,
    input  rv_pkg::word_t     rd_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    word_t regs [NUM_REGS];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];   // x0 hardwired
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wen && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-3:0]       mem_addr_t;   // byte address minus [1:0]

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_xor,
        alu_or,
        alu_and,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_j
    } imm_fmt_e;

    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t FWD_REG = 2'd0;   // register file / pipeline reg value
    localparam fwd_sel_t FWD_MEM = 2'd1;   // EX/MEM result
    localparam fwd_sel_t FWD_WB  = 2'd2;   // writeback value

    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BNE = 3'b001;

    // operand bypass shared by decode and execute
    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage
